//--- icache_subsys.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/cache_req_if.sv
verilog/refill_if.sv
verilog/fetch_queue.sv
verilog/line_ram.sv
verilog/icache.sv
verilog/refill_unit.sv
verilog/icache_subsys.sv
verif/tb_icache_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert --top-module tb_icache_subsys \
    -f icache_subsys.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

//--- verif/tb_icache_subsys.sv
`include "icache_consts.svh"

module tb_icache_subsys;

    localparam int TBL_N  = 12;
    localparam int RAND_N = 16;
    localparam int LIMIT  = (TBL_N + RAND_N) * 16 + 8;
    localparam logic [31:0] KEY = 32'hc0de0000;

    logic                      clk;
    logic                      rst;
    logic                      fetch_valid;
    logic [`ICACHE_ADDR_W-1:0] fetch_addr;
    logic                      fetch_ready;
    logic                      inst_valid;
    logic [31:0]               inst_data;
    logic                      mem_req;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic                      mem_rvalid;
    logic [`ICACHE_LINE_W-1:0] mem_rdata;

    // fetch address and miss expectation, 2 means either
    logic [31:0] tbl_addr [TBL_N] = '{
        32'h0000_1000, 32'h0000_1004, 32'h0000_1000, 32'h0000_1233,
        32'h0000_2000, 32'h0000_1004, 32'h0000_2004, 32'h0000_1000,
        32'h0000_2000, 32'h0040_0010, 32'h0040_0014, 32'h0040_0010
    };
    logic [1:0]  tbl_miss [TBL_N] = '{
        2'd1, 2'd0, 2'd0, 2'd1,
        2'd1, 2'd2, 2'd2, 2'd2,
        2'd2, 2'd1, 2'd0, 2'd0
    };

    logic [31:0] rand_addr [RAND_N];
    logic [31:0] exp_q [$];
    logic [31:0] lfsr_state = 32'h64be;
    logic [31:0] bits;
    logic [31:0] delay_bits;
    logic [1:0]  mem_wait;
    logic        mem_busy = 1'b0;
    logic [31:0] last_mem_addr = '0;
    logic        ready_seen = 1'b0;
    logic        saw_full = 1'b0;
    int          accepted_cnt = 0;
    int          received_cnt = 0;
    int          miss_cnt = 0;
    int          miss_before = 0;
    int          cycle_cnt = 0;

    icache_subsys DUT (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .inst_valid  (inst_valid),
        .inst_data   (inst_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] f);
        return {f[31:2], 2'b00} ^ KEY;
    endfunction

    // low word at the line address, high word four bytes on
    function automatic logic [63:0] line_data(input logic [31:0] a);
        return {(a + 32'd4) ^ KEY, a ^ KEY};
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // called on a falling edge, returns one falling edge after the handshake
    task automatic push_fetch(input logic [31:0] addr);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        while (!fetch_ready) @(negedge clk);
        exp_q.push_back(addr);
        accepted_cnt++;
        @(negedge clk);
    endtask

    task automatic wait_drain();
        wait (received_cnt == accepted_cnt);
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: the run took more than %0d cycles", LIMIT);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    // result checker and memory model
    always @(negedge clk) begin
        if (rst) begin
            mem_rvalid = 1'b0;
            mem_busy   = 1'b0;
        end else begin
            if (fetch_ready) begin
                ready_seen = 1'b1;
            end else if (ready_seen) begin
                saw_full = 1'b1;
                check_equal(64'(accepted_cnt - received_cnt >= 4), 64'd1,
                            "fetch_ready low with fewer than four fetches waiting");
            end
            if (inst_valid) begin
                if (exp_q.size() == 0) begin
                    $display("a result arrived with no fetch waiting for it");
                    $display("TB FAILED");
                    $fatal(1);
                end else begin
                    check_equal(64'(inst_data), 64'(expected_word(exp_q[0])),
                                "instruction word");
                    exp_q.delete(0);
                    received_cnt++;
                end
            end
            mem_rvalid = 1'b0;
            if (mem_req && !mem_busy) begin
                // answer in 1 to 4 cycles
                mem_busy = 1'b1;
                miss_cnt++;
                last_mem_addr = mem_addr;
                draw_bits(2, delay_bits);
                mem_wait = delay_bits[1:0];
            end
            if (mem_busy) begin
                if (mem_wait == 2'd0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = line_data(mem_addr);
                    mem_busy   = 1'b0;
                end else begin
                    mem_wait = mem_wait - 2'd1;
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        // burst addresses drawn before any memory delay
        for (int i = 0; i < RAND_N; i++) begin
            draw_bits(12, bits);
            rand_addr[i] = {20'h00001, bits[11:0]};
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_equal(64'(mem_req), 64'd0, "mem_req after reset");
        check_equal(64'(inst_valid), 64'd0, "inst_valid after reset");
        @(negedge clk);
        check_equal(64'(fetch_ready), 64'd1, "fetch_ready before the first push");

        for (int i = 0; i < TBL_N; i++) begin
            miss_before = miss_cnt;
            push_fetch(tbl_addr[i]);
            fetch_valid = 1'b0;
            wait_drain();
            if (tbl_miss[i] != 2'd2) begin
                check_equal(64'(miss_cnt != miss_before), 64'(tbl_miss[i]),
                            "miss expectation");
            end
            if (tbl_miss[i] == 2'd1) begin
                check_equal(64'(last_mem_addr), 64'({tbl_addr[i][31:3], 3'b000}),
                            "refill line address");
            end
        end

        // back-to-back pushes, the queue fills behind the cache
        for (int i = 0; i < RAND_N; i++) begin
            push_fetch(rand_addr[i]);
        end
        fetch_valid = 1'b0;
        wait_drain();
        check_equal(64'(saw_full), 64'd1, "fetch_ready low during the burst");
        // a stray result here finds no fetch to match
        repeat (4) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verilog/cache_req_if.sv
interface cache_req_if;

    logic                    valid;
    icache_pkg::fetch_addr_t addr;
    logic                    addr_ok;
    logic                    data_ok;
    logic [31:0]             rdata;

    // fetch queue side
    modport producer (
        output valid,
        output addr,
        input  addr_ok,
        input  data_ok,
        input  rdata
    );

    modport cache (
        input  valid,
        input  addr,
        output addr_ok,
        output data_ok,
        output rdata
    );

endinterface

//--- verilog/fetch_queue.sv
`include "icache_consts.svh"

module fetch_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_valid,
    input  icache_pkg::fetch_addr_t fetch_addr,
    output logic                    fetch_ready,
    cache_req_if.producer           cache
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`ICACHE_ADDR_W-1:0] buf_mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [PTR_W:0]            count;
    logic                      outstanding;
    logic                      ready_en;
    logic                      full;
    logic                      push;
    logic                      pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full        = (count == (PTR_W + 1)'(DEPTH));
    assign fetch_ready = ready_en && !full;
    assign push        = fetch_valid && fetch_ready;
    assign pop         = cache.valid && cache.addr_ok;

    // offer the head only when nothing is in flight
    assign cache.valid = (count != '0) && !outstanding;
    assign cache.addr  = buf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= fetch_addr.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            outstanding <= 1'b0;
            ready_en    <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
            // cleared by the cache's data_ok
            if (pop) begin
                outstanding <= 1'b1;
            end else if (cache.data_ok) begin
                outstanding <= 1'b0;
            end
        end
    end

    // a write into a full buffer would push the count past the depth
    assert property (@(posedge clk) disable iff (rst)
        (count <= (PTR_W + 1)'(DEPTH)) && (!full || (wr_ptr == rd_ptr)))
        else $error("fetch queue overfilled or pointers out of step with the count");

endmodule

//--- verilog/icache.sv
`include "icache_consts.svh"

module icache (
    input  logic      clk,
    input  logic      rst,
    cache_req_if.cache req,
    refill_if.cache    refill
);

    localparam int HALF_W = `ICACHE_LINE_W / 2;

    icache_pkg::cache_state_t   state;
    icache_pkg::cache_state_t   next_state;

    icache_pkg::fetch_addr_t    req_addr;
    logic [`ICACHE_INDEX_W-1:0] idx;
    logic [`ICACHE_TAG_W-1:0]   tag;

    logic [`ICACHE_TAG_W-1:0]   tag_tab [2][`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]    valid_tab [2];

    logic [1:0]                 way_hit;
    logic [1:0]                 hit_q;
    logic                       replace_way;
    logic [`ICACHE_LINE_W-1:0]  fill_line;

    logic                       ram_rd_en;
    logic                       ram_wr_en;
    logic [`ICACHE_LINE_W-1:0]  way0_line;
    logic [`ICACHE_LINE_W-1:0]  way1_line;
    logic [`ICACHE_LINE_W-1:0]  hit_line;

    assign idx = req_addr.f.index;
    assign tag = req_addr.f.tag;

    // request buffer
    always_ff @(posedge clk) begin
        if (req.valid && req.addr_ok) begin
            req_addr <= req.addr;
        end
    end

    // tag compare on the registered request
    assign way_hit[0] = valid_tab[0][idx] && (tag_tab[0][idx] == tag);
    assign way_hit[1] = valid_tab[1][idx] && (tag_tab[1][idx] == tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= '0;
        end else if (state == icache_pkg::LOOKUP) begin
            hit_q <= way_hit;
        end
    end

    // free-running victim pick
    always_ff @(posedge clk) begin
        if (rst) begin
            replace_way <= 1'b0;
        end else begin
            replace_way <= ~replace_way;
        end
    end

    // hold the returned line until REPLACE
    always_ff @(posedge clk) begin
        if (state == icache_pkg::MISS && refill.valid) begin
            fill_line <= refill.data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == icache_pkg::REPLACE) begin
            tag_tab[replace_way][idx] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_tab[0] <= '0;
            valid_tab[1] <= '0;
        end else if (state == icache_pkg::REPLACE) begin
            valid_tab[replace_way][idx] <= 1'b1;
        end
    end

    assign ram_rd_en = (state == icache_pkg::LOOKUP) && (|way_hit);
    assign ram_wr_en = (state == icache_pkg::REPLACE);

    line_ram u_line_ram (
        .clk       (clk),
        .index     (idx),
        .rd_en     (ram_rd_en),
        .wr_en     (ram_wr_en),
        .wr_way    (replace_way),
        .wr_line   (fill_line),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

    // way select, then word by offset bit 2
    assign hit_line = ({`ICACHE_LINE_W{hit_q[0]}} & way0_line)
                    | ({`ICACHE_LINE_W{hit_q[1]}} & way1_line);

    assign req.addr_ok = (state == icache_pkg::IDLE);
    assign req.data_ok = (state == icache_pkg::RESPOND);
    assign req.rdata   = req_addr.f.offset[2] ? hit_line[`ICACHE_LINE_W-1:HALF_W]
                                              : hit_line[HALF_W-1:0];

    assign refill.req  = (state == icache_pkg::MISS);
    assign refill.addr = req_addr;

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (req.valid) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (|way_hit) begin
                    next_state = icache_pkg::RESPOND;
                end else begin
                    next_state = icache_pkg::MISS;
                end
            end
            icache_pkg::RESPOND: next_state = icache_pkg::IDLE;
            icache_pkg::MISS: begin
                if (refill.valid) begin
                    next_state = icache_pkg::REPLACE;
                end
            end
            // re-run the lookup, which now hits
            icache_pkg::REPLACE: next_state = icache_pkg::LOOKUP;
            default: next_state = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        req.data_ok |=> !req.data_ok)
        else $error("data_ok held for two cycles");

    // a line is never installed in both ways
    assert property (@(posedge clk) disable iff (rst)
        (state == icache_pkg::LOOKUP) |-> $onehot0(way_hit))
        else $error("both ways hit the same request");

endmodule

//--- verilog/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address split: tag | index | offset
`define ICACHE_ADDR_W 32
`define ICACHE_TAG_W 23
`define ICACHE_INDEX_W 6
`define ICACHE_OFFSET_W 3

// two ways of 64 sets, one 8-byte line each
`define ICACHE_SETS 64
`define ICACHE_LINE_W 64

// pending fetch addresses
`define FETCH_QUEUE_DEPTH 4

`endif

//--- verilog/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // field view of a fetch address, msb first
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // raw word for the queue and refill path, fields for the cache
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } fetch_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        MISS,
        REPLACE
    } cache_state_t;

endpackage

//--- verilog/icache_subsys.sv
`include "icache_consts.svh"

module icache_subsys (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      fetch_valid,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr,
    output logic                      fetch_ready,

    output logic                      inst_valid,
    output logic [31:0]               inst_data,

    output logic                      mem_req,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  logic                      mem_rvalid,
    input  logic [`ICACHE_LINE_W-1:0] mem_rdata
);

    icache_pkg::fetch_addr_t fetch_word;

    cache_req_if req_bus ();
    refill_if    refill_bus ();

    assign fetch_word = fetch_addr;

    fetch_queue u_fetch_queue (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_word),
        .fetch_ready (fetch_ready),
        .cache       (req_bus.producer)
    );

    icache u_icache (
        .clk    (clk),
        .rst    (rst),
        .req    (req_bus.cache),
        .refill (refill_bus.cache)
    );

    refill_unit u_refill_unit (
        .clk        (clk),
        .rst        (rst),
        .refill     (refill_bus.memory),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    // fetched words leave straight from the cache response
    assign inst_valid = req_bus.data_ok;
    assign inst_data  = req_bus.rdata;

endmodule

//--- verilog/line_ram.sv
`include "icache_consts.svh"

module line_ram (
    input  logic                       clk,
    input  logic [`ICACHE_INDEX_W-1:0] index,
    input  logic                       rd_en,
    input  logic                       wr_en,
    input  logic                       wr_way,
    input  logic [`ICACHE_LINE_W-1:0]  wr_line,
    output logic [`ICACHE_LINE_W-1:0]  way0_line,
    output logic [`ICACHE_LINE_W-1:0]  way1_line
);

    logic [`ICACHE_LINE_W-1:0] way0_mem [`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] way1_mem [`ICACHE_SETS];

    // per-way write
    always_ff @(posedge clk) begin
        if (wr_en && !wr_way) begin
            way0_mem[index] <= wr_line;
        end
        if (wr_en && wr_way) begin
            way1_mem[index] <= wr_line;
        end
    end

    // both ways read together, valid next cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            way0_line <= way0_mem[index];
            way1_line <= way1_mem[index];
        end
    end

endmodule

//--- verilog/refill_if.sv
`include "icache_consts.svh"

interface refill_if;

    logic                       req;
    icache_pkg::fetch_addr_t    addr;
    logic                       valid;
    logic [`ICACHE_LINE_W-1:0]  data;

    // req held for the whole miss
    modport cache (
        output req,
        output addr,
        input  valid,
        input  data
    );

    modport memory (
        input  req,
        input  addr,
        output valid,
        output data
    );

endinterface

//--- verilog/refill_unit.sv
`include "icache_consts.svh"

module refill_unit (
    input  logic                      clk,
    input  logic                      rst,
    refill_if.memory                  refill,
    output logic                      mem_req,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    input  logic                      mem_rvalid,
    input  logic [`ICACHE_LINE_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,
        R_RETURN
    } refill_state_t;

    refill_state_t             state;
    logic                      req_d;
    logic                      start;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    logic [`ICACHE_LINE_W-1:0] line_q;

    // new miss on the rising edge of req
    assign start = refill.req && !req_d;

    assign mem_req      = (state == R_WAIT);
    assign mem_addr     = addr_q;
    assign refill.valid = (state == R_RETURN);
    assign refill.data  = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= R_IDLE;
            req_d <= 1'b0;
        end else begin
            req_d <= refill.req;
            case (state)
                R_IDLE: if (start) state <= R_WAIT;
                R_WAIT: if (mem_rvalid) state <= R_RETURN;
                default: state <= R_IDLE;
            endcase
        end
    end

    // line-aligned address, line captured on return
    always_ff @(posedge clk) begin
        if (state == R_IDLE && start) begin
            addr_q <= {refill.addr.raw[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                       {`ICACHE_OFFSET_W{1'b0}}};
        end
        if (state == R_WAIT && mem_rvalid) begin
            line_q <= mem_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_rvalid) |=> (mem_req && $stable(mem_addr)))
        else $error("memory address changed during a pending read");

endmodule
